// File: hdl/decode_pkg.sv
// Decode stage shared types
`default_nettype none

package decode_pkg;

  localparam int XLEN        = 32;
  localparam int REG_ADDR_W  = 5;
  localparam int TAG_W       = 4;
  localparam int MEM_WIDTH_W = 3;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [TAG_W-1:0]      tag_t;

  // RV32 major opcodes in the supported subset
  typedef enum logic [6:0] {
    OP       = 7'b0110011,
    OP_IMM   = 7'b0010011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    MISC_MEM = 7'b0001111
  } opcode_t;

  // Dispatch target
  typedef enum logic [1:0] {
    UNIT_NONE,
    UNIT_ARITH,
    UNIT_MUL,
    UNIT_LS
  } unit_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC_A_RS1,
    SRC_A_PC,
    SRC_A_ZERO
  } src_a_t;

  typedef enum logic [1:0] {
    SRC_B_RS2,
    SRC_B_IMM,
    SRC_B_UIMM
  } src_b_t;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_U
  } imm_kind_t;

endpackage

`default_nettype wire

// File: hdl/decoded_if.sv
// Decoded instruction bundle
`timescale 1ns/1ns
`default_nettype none

interface decoded_if;
  import decode_pkg::*;

  unit_t                  unit;
  alu_op_t                alu_op;
  src_a_t                 src_a;
  src_b_t                 src_b;
  imm_kind_t              imm_kind;
  reg_addr_t              rd;
  logic                   mul_high;
  logic                   mul_signed;
  logic                   is_load;
  logic                   is_store;
  logic [MEM_WIDTH_W-1:0] mem_width;
  logic                   is_fence;
  logic                   illegal;

  modport source (
    output unit, alu_op, src_a, src_b, imm_kind, rd, mul_high, mul_signed,
           is_load, is_store, mem_width, is_fence, illegal
  );

  modport sink (
    input unit, alu_op, src_a, src_b, imm_kind, rd, mul_high, mul_signed,
          is_load, is_store, mem_width, is_fence, illegal
  );

endinterface

`default_nettype wire

// File: hdl/instr_decoder.sv
// RV32 subset instruction decoder
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  decode_pkg::word_t     instr,
  decoded_if.source             dec,
  output decode_pkg::reg_addr_t rs1_addr,
  output decode_pkg::reg_addr_t rs2_addr
);
  import decode_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Common funct3 mapping for OP and OP-IMM
  function automatic alu_op_t base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode   = opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  always_comb begin
    dec.unit       = UNIT_ARITH;
    dec.alu_op     = ALU_ADD;
    dec.src_a      = SRC_A_RS1;
    dec.src_b      = SRC_B_RS2;
    dec.imm_kind   = IMM_I;
    dec.rd         = instr[11:7];
    dec.mul_high   = 1'b0;
    dec.mul_signed = 1'b0;
    dec.is_load    = 1'b0;
    dec.is_store   = 1'b0;
    dec.mem_width  = funct3;
    dec.is_fence   = 1'b0;
    dec.illegal    = 1'b0;

    case (opcode)
      OP: begin
        if (funct7 == 7'b0000000) begin
          dec.alu_op = base_op(funct3);
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.alu_op = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          dec.alu_op = ALU_SRA;
        end else if (funct7 == 7'b0000001) begin
          dec.unit       = UNIT_MUL;
          // MUL, MULH and MULHU only
          dec.mul_high   = funct3[0] | funct3[1];
          dec.mul_signed = ~funct3[1];
          dec.illegal    = funct3[2] | (funct3[1:0] == 2'b10);
        end else begin
          dec.illegal = 1'b1;
        end
      end
      OP_IMM: begin
        dec.src_b  = SRC_B_IMM;
        dec.alu_op = base_op(funct3);
        // Shift amounts need a clean upper field
        if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
          dec.alu_op = ALU_SRA;
        end else if (funct3[1:0] == 2'b01 && funct7 != 7'b0000000) begin
          dec.illegal = 1'b1;
        end
      end
      LUI: begin
        dec.src_a    = SRC_A_ZERO;
        dec.src_b    = SRC_B_UIMM;
        dec.imm_kind = IMM_U;
      end
      AUIPC: begin
        dec.src_a    = SRC_A_PC;
        dec.src_b    = SRC_B_UIMM;
        dec.imm_kind = IMM_U;
      end
      LOAD: begin
        dec.unit    = UNIT_LS;
        dec.src_b   = SRC_B_IMM;
        dec.is_load = 1'b1;
        dec.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      STORE: begin
        dec.unit     = UNIT_LS;
        dec.src_b    = SRC_B_IMM;
        dec.imm_kind = IMM_S;
        dec.rd       = '0;
        dec.is_store = 1'b1;
        dec.illegal  = funct3[2] | (funct3[1:0] == 2'b11);
      end
      MISC_MEM: begin
        dec.rd = '0;
        if (funct3 == 3'b001) begin
          dec.unit     = UNIT_NONE;
          dec.is_fence = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: dec.illegal = 1'b1;
    endcase

    // Anything outside the subset goes to the ALU as a flagged ADD
    if (dec.illegal) begin
      dec.unit       = UNIT_ARITH;
      dec.alu_op     = ALU_ADD;
      dec.mul_high   = 1'b0;
      dec.mul_signed = 1'b0;
      dec.is_load    = 1'b0;
      dec.is_store   = 1'b0;
    end
  end

  always_comb begin
    assert (!(dec.is_fence && dec.illegal))
      else $error("fence.i decoded as illegal");
  end

endmodule

`default_nettype wire

// File: hdl/operand_select.sv
// Immediate build and operand muxes
`timescale 1ns/1ns
`default_nettype none

module operand_select (
  input  decode_pkg::word_t instr,
  input  decode_pkg::word_t pc,
  input  decode_pkg::word_t rs1_data,
  input  decode_pkg::word_t rs2_data,
  decoded_if.sink           dec,
  output decode_pkg::word_t port_a,
  output decode_pkg::word_t port_b,
  output decode_pkg::word_t store_data
);
  import decode_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t imm_ext;

  // I format also carries shamt in its low bits
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};

  always_comb begin
    case (dec.imm_kind)
      IMM_S:   imm_ext = imm_s;
      IMM_U:   imm_ext = imm_u;
      default: imm_ext = imm_i;
    endcase
  end

  // Loads and stores see base on A, offset on B
  always_comb begin
    case (dec.src_a)
      SRC_A_PC:   port_a = pc;
      SRC_A_ZERO: port_a = '0;
      default:    port_a = rs1_data;
    endcase
  end

  always_comb begin
    case (dec.src_b)
      SRC_B_IMM:  port_b = imm_ext;
      SRC_B_UIMM: port_b = imm_u;
      default:    port_b = rs2_data;
    endcase
  end

  assign store_data = rs2_data;

endmodule

`default_nettype wire

// File: hdl/dispatch_latches.sv
// Per-unit dispatch registers
`timescale 1ns/1ns
`default_nettype none

module dispatch_latches (
  input  logic                                 CLK,
  input  logic                                 nRST,
  input  logic                                 instr_valid,
  input  logic                                 flush,
  input  logic                                 stall_arith,
  input  logic                                 stall_mul,
  input  logic                                 stall_ls,
  input  logic                                 fence_busy,
  input  decode_pkg::tag_t                     cb_tail,
  decoded_if.sink                              dec,
  input  decode_pkg::word_t                    port_a,
  input  decode_pkg::word_t                    port_b,
  input  decode_pkg::word_t                    store_data,
  output logic                                 arith_valid,
  output decode_pkg::alu_op_t                  arith_op,
  output decode_pkg::word_t                    arith_a,
  output decode_pkg::word_t                    arith_b,
  output decode_pkg::reg_addr_t                arith_rd,
  output logic                                 arith_illegal,
  output decode_pkg::tag_t                     arith_tag,
  output logic                                 mul_valid,
  output logic                                 mul_high,
  output logic                                 mul_signed,
  output decode_pkg::word_t                    mul_a,
  output decode_pkg::word_t                    mul_b,
  output decode_pkg::reg_addr_t                mul_rd,
  output decode_pkg::tag_t                     mul_tag,
  output logic                                 ls_valid,
  output logic                                 ls_load,
  output logic                                 ls_store,
  output logic [decode_pkg::MEM_WIDTH_W-1:0]   ls_width,
  output decode_pkg::word_t                    ls_base,
  output decode_pkg::word_t                    ls_offset,
  output decode_pkg::word_t                    ls_store_data,
  output decode_pkg::reg_addr_t                ls_rd,
  output decode_pkg::tag_t                     ls_tag,
  output logic                                 accept,
  output logic                                 decode_stall
);
  import decode_pkg::*;

  logic unit_stall;
  logic load_arith;
  logic load_mul;
  logic load_ls;

  always_comb begin
    case (dec.unit)
      UNIT_ARITH: unit_stall = stall_arith;
      UNIT_MUL:   unit_stall = stall_mul;
      UNIT_LS:    unit_stall = stall_ls;
      default:    unit_stall = 1'b0;
    endcase
  end

  assign accept       = instr_valid & ~unit_stall & ~fence_busy;
  assign decode_stall = instr_valid & (unit_stall | fence_busy);

  assign load_arith = accept && dec.unit == UNIT_ARITH;
  assign load_mul   = accept && dec.unit == UNIT_MUL;
  assign load_ls    = accept && dec.unit == UNIT_LS;

  // Stalled units keep their valid, idle units drop it
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      arith_valid <= 1'b0;
      mul_valid   <= 1'b0;
      ls_valid    <= 1'b0;
    end else if (flush) begin
      arith_valid <= 1'b0;
      mul_valid   <= 1'b0;
      ls_valid    <= 1'b0;
    end else begin
      if (~stall_arith)
        arith_valid <= load_arith;
      if (~stall_mul)
        mul_valid <= load_mul;
      if (~stall_ls)
        ls_valid <= load_ls;
    end
  end

  always_ff @(posedge CLK) begin
    if (load_arith) begin
      arith_op      <= dec.alu_op;
      arith_a       <= port_a;
      arith_b       <= port_b;
      arith_rd      <= dec.rd;
      arith_illegal <= dec.illegal;
      arith_tag     <= cb_tail;
    end
    if (load_mul) begin
      mul_high   <= dec.mul_high;
      mul_signed <= dec.mul_signed;
      mul_a      <= port_a;
      mul_b      <= port_b;
      mul_rd     <= dec.rd;
      mul_tag    <= cb_tail;
    end
    if (load_ls) begin
      ls_load       <= dec.is_load;
      ls_store      <= dec.is_store;
      ls_width      <= dec.mem_width;
      ls_base       <= port_a;
      ls_offset     <= port_b;
      ls_store_data <= store_data;
      ls_rd         <= dec.rd;
      ls_tag        <= cb_tail;
    end
  end

  assert property (@(posedge CLK) disable iff (~nRST) $onehot0({load_arith, load_mul, load_ls}));

  // Back-pressure holds the whole latch
  assert property (@(posedge CLK) disable iff (~nRST) stall_arith && !flush |=>
    $stable({arith_valid, arith_op, arith_a, arith_b, arith_rd, arith_illegal, arith_tag}));
  assert property (@(posedge CLK) disable iff (~nRST) stall_mul && !flush |=>
    $stable({mul_valid, mul_high, mul_signed, mul_a, mul_b, mul_rd, mul_tag}));
  assert property (@(posedge CLK) disable iff (~nRST) stall_ls && !flush |=>
    $stable({ls_valid, ls_load, ls_store, ls_width, ls_base, ls_offset, ls_store_data,
             ls_rd, ls_tag}));

endmodule

`default_nettype wire

// File: hdl/fence_tracker.sv
// FENCE.I flush control
`timescale 1ns/1ns
`default_nettype none

module fence_tracker (
  input  logic    CLK,
  input  logic    nRST,
  decoded_if.sink dec,
  input  logic    accept,
  input  logic    icache_done,
  input  logic    dcache_done,
  output logic    icache_flush,
  output logic    dcache_flush,
  output logic    fence_busy
);

  logic prev_fence;
  logic fence_start;
  logic iflushed;
  logic dflushed;

  // Only the first of a run of fences flushes
  assign fence_start = accept & dec.is_fence & ~prev_fence;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      prev_fence   <= 1'b0;
      icache_flush <= 1'b0;
      dcache_flush <= 1'b0;
      fence_busy   <= 1'b0;
      iflushed     <= 1'b0;
      dflushed     <= 1'b0;
    end else begin
      if (accept)
        prev_fence <= dec.is_fence;
      icache_flush <= fence_start;
      dcache_flush <= fence_start;
      if (fence_start) begin
        fence_busy <= 1'b1;
        iflushed   <= 1'b0;
        dflushed   <= 1'b0;
      end else if (fence_busy) begin
        // Done strobes are sticky until the next fence
        if (icache_done)
          iflushed <= 1'b1;
        if (dcache_done)
          dflushed <= 1'b1;
        if (iflushed && dflushed)
          fence_busy <= 1'b0;
      end
    end
  end

  assert property (@(posedge CLK) disable iff (~nRST) icache_flush |=> !icache_flush);

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
// Out-of-order decode stage top
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic                               CLK,
  input  logic                               nRST,
  input  decode_pkg::word_t                  instr,
  input  decode_pkg::word_t                  pc,
  input  logic                               instr_valid,
  input  logic                               flush,
  input  logic                               stall_arith,
  input  logic                               stall_mul,
  input  logic                               stall_ls,
  input  decode_pkg::tag_t                   cb_tail,
  input  decode_pkg::word_t                  rs1_data,
  input  decode_pkg::word_t                  rs2_data,
  input  logic                               icache_done,
  input  logic                               dcache_done,
  output decode_pkg::reg_addr_t              rs1_addr,
  output decode_pkg::reg_addr_t              rs2_addr,
  output logic                               decode_stall,
  output logic                               arith_valid,
  output decode_pkg::alu_op_t                arith_op,
  output decode_pkg::word_t                  arith_a,
  output decode_pkg::word_t                  arith_b,
  output decode_pkg::reg_addr_t              arith_rd,
  output logic                               arith_illegal,
  output decode_pkg::tag_t                   arith_tag,
  output logic                               mul_valid,
  output logic                               mul_high,
  output logic                               mul_signed,
  output decode_pkg::word_t                  mul_a,
  output decode_pkg::word_t                  mul_b,
  output decode_pkg::reg_addr_t              mul_rd,
  output decode_pkg::tag_t                   mul_tag,
  output logic                               ls_valid,
  output logic                               ls_load,
  output logic                               ls_store,
  output logic [decode_pkg::MEM_WIDTH_W-1:0] ls_width,
  output decode_pkg::word_t                  ls_base,
  output decode_pkg::word_t                  ls_offset,
  output decode_pkg::word_t                  ls_store_data,
  output decode_pkg::reg_addr_t              ls_rd,
  output decode_pkg::tag_t                   ls_tag,
  output logic                               icache_flush,
  output logic                               dcache_flush,
  output logic                               fence_busy
);
  import decode_pkg::*;

  word_t port_a;
  word_t port_b;
  word_t store_data;
  logic  accept;

  decoded_if dec_bus ();

  instr_decoder u_decoder (
    .instr    (instr),
    .dec      (dec_bus.source),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr)
  );

  operand_select u_operands (
    .instr      (instr),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dec        (dec_bus.sink),
    .port_a     (port_a),
    .port_b     (port_b),
    .store_data (store_data)
  );

  dispatch_latches u_latches (
    .CLK           (CLK),
    .nRST          (nRST),
    .instr_valid   (instr_valid),
    .flush         (flush),
    .stall_arith   (stall_arith),
    .stall_mul     (stall_mul),
    .stall_ls      (stall_ls),
    .fence_busy    (fence_busy),
    .cb_tail       (cb_tail),
    .dec           (dec_bus.sink),
    .port_a        (port_a),
    .port_b        (port_b),
    .store_data    (store_data),
    .arith_valid   (arith_valid),
    .arith_op      (arith_op),
    .arith_a       (arith_a),
    .arith_b       (arith_b),
    .arith_rd      (arith_rd),
    .arith_illegal (arith_illegal),
    .arith_tag     (arith_tag),
    .mul_valid     (mul_valid),
    .mul_high      (mul_high),
    .mul_signed    (mul_signed),
    .mul_a         (mul_a),
    .mul_b         (mul_b),
    .mul_rd        (mul_rd),
    .mul_tag       (mul_tag),
    .ls_valid      (ls_valid),
    .ls_load       (ls_load),
    .ls_store      (ls_store),
    .ls_width      (ls_width),
    .ls_base       (ls_base),
    .ls_offset     (ls_offset),
    .ls_store_data (ls_store_data),
    .ls_rd         (ls_rd),
    .ls_tag        (ls_tag),
    .accept        (accept),
    .decode_stall  (decode_stall)
  );

  fence_tracker u_fence (
    .CLK          (CLK),
    .nRST         (nRST),
    .dec          (dec_bus.sink),
    .accept       (accept),
    .icache_done  (icache_done),
    .dcache_done  (dcache_done),
    .icache_flush (icache_flush),
    .dcache_flush (dcache_flush),
    .fence_busy   (fence_busy)
  );

endmodule

`default_nettype wire

// File: bench/decode_stage_tb.sv
// Decode stage testbench
`timescale 1ns/1ns
`default_nettype none

module decode_stage_tb;
  import decode_pkg::*;

  localparam word_t REG_SCALE = 32'h0101_0037;

  logic CLK, nRST, instr_valid, flush, stall_arith, stall_mul, stall_ls;
  logic icache_done, dcache_done;
  word_t instr, pc, rs1_data, rs2_data;
  tag_t cb_tail;
  reg_addr_t rs1_addr, rs2_addr;
  logic decode_stall, icache_flush, dcache_flush, fence_busy;
  logic arith_valid, arith_illegal, mul_valid, mul_high, mul_signed;
  logic ls_valid, ls_load, ls_store;
  alu_op_t arith_op;
  word_t arith_a, arith_b, mul_a, mul_b, ls_base, ls_offset, ls_store_data;
  reg_addr_t arith_rd, mul_rd, ls_rd;
  tag_t arith_tag, mul_tag, ls_tag;
  logic [MEM_WIDTH_W-1:0] ls_width;

  // Reference model state
  logic m_arith_valid = 0, m_arith_illegal = 0, m_mul_valid = 0, m_mul_high = 0;
  logic m_mul_signed = 0, m_ls_valid = 0, m_ls_load = 0, m_ls_store = 0;
  logic m_iflush = 0, m_dflush = 0, m_busy = 0, m_prev = 0, m_si = 0, m_sd = 0;
  alu_op_t m_arith_op = ALU_ADD;
  word_t m_arith_a = 0, m_arith_b = 0, m_mul_a = 0, m_mul_b = 0;
  word_t m_ls_base = 0, m_ls_offset = 0, m_ls_data = 0;
  reg_addr_t m_arith_rd = 0, m_mul_rd = 0, m_ls_rd = 0;
  tag_t m_arith_tag = 0, m_mul_tag = 0, m_ls_tag = 0;
  logic [MEM_WIDTH_W-1:0] m_ls_width = 0;
  logic m_stall;

  int errors = 0;
  int tests = 0;
  int test_start_errors = 0;
  bit chk_en = 0;

  decode_stage uut (.*);

  // Register file returns a scaled register number
  assign rs1_data = word_t'(rs1_addr) * REG_SCALE;
  assign rs2_data = word_t'(rs2_addr) * REG_SCALE;

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    #40000;
    $display("Simulation timeout, the stimulus never finished");
    $display("Done: errors found");
    $finish;
  end

  function automatic alu_op_t alu_of(input logic [2:0] f3);
    case (f3)
      3'd0: return ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Expected decode from the RV32 encoding rules
  task automatic predict(input word_t ins, input word_t ipc, output unit_t u,
                         output alu_op_t op, output word_t a, output word_t b,
                         output logic ill, output logic mh, output logic ms,
                         output logic ld, output logic st, output logic fe,
                         output reg_addr_t rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = ins[14:12];
    f7 = ins[31:25];
    u = UNIT_ARITH;
    op = ALU_ADD;
    a = word_t'(ins[19:15]) * REG_SCALE;
    b = word_t'(ins[24:20]) * REG_SCALE;
    rd = ins[11:7];
    {ill, mh, ms, ld, st, fe} = '0;
    case (ins[6:0])
      7'h33: begin
        if (f7 == 7'h01 && (f3 == 0 || f3 == 1 || f3 == 3)) begin
          u = UNIT_MUL;
          mh = f3 != 0;
          ms = f3 != 3;
        end else if (f7 == 7'h00) op = alu_of(f3);
        else if (f7 == 7'h20 && f3 == 0) op = ALU_SUB;
        else if (f7 == 7'h20 && f3 == 5) op = ALU_SRA;
        else ill = 1'b1;
      end
      7'h13: begin
        op = (f3 == 5 && f7 == 7'h20) ? ALU_SRA : alu_of(f3);
        b = {{20{ins[31]}}, ins[31:20]};
      end
      7'h37: begin
        a = '0;
        b = {ins[31:12], 12'h000};
      end
      7'h17: begin
        a = ipc;
        b = {ins[31:12], 12'h000};
      end
      7'h03: begin
        u = UNIT_LS;
        ld = 1'b1;
        b = {{20{ins[31]}}, ins[31:20]};
      end
      7'h23: begin
        u = UNIT_LS;
        st = 1'b1;
        rd = '0;
        b = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      end
      7'h0f: begin
        u = UNIT_NONE;
        fe = 1'b1;
        rd = '0;
      end
      default: ill = 1'b1;
    endcase
  endtask

  function automatic logic unit_stall_of(input unit_t u);
    case (u)
      UNIT_ARITH: return stall_arith;
      UNIT_MUL:   return stall_mul;
      UNIT_LS:    return stall_ls;
      default:    return 1'b0;
    endcase
  endfunction

  always @(posedge CLK or negedge nRST) begin : ref_model
    unit_t u;
    alu_op_t op;
    word_t a, b;
    logic ill, mh, ms, ld, st, fe, acc, start, both_seen;
    reg_addr_t rd;
    if (!nRST) begin
      {m_arith_valid, m_mul_valid, m_ls_valid} = '0;
      {m_iflush, m_dflush, m_busy, m_prev, m_si, m_sd} = '0;
    end else begin
      predict(instr, pc, u, op, a, b, ill, mh, ms, ld, st, fe, rd);
      acc = instr_valid && !unit_stall_of(u) && !m_busy;
      start = acc && fe && !m_prev;
      if (flush) begin
        {m_arith_valid, m_mul_valid, m_ls_valid} = '0;
      end else begin
        if (!stall_arith) m_arith_valid = acc && u == UNIT_ARITH;
        if (!stall_mul) m_mul_valid = acc && u == UNIT_MUL;
        if (!stall_ls) m_ls_valid = acc && u == UNIT_LS;
      end
      if (acc && u == UNIT_ARITH) begin
        m_arith_op      = op;
        m_arith_a       = a;
        m_arith_b       = b;
        m_arith_rd      = rd;
        m_arith_illegal = ill;
        m_arith_tag     = cb_tail;
      end
      if (acc && u == UNIT_MUL) begin
        m_mul_high   = mh;
        m_mul_signed = ms;
        m_mul_a      = a;
        m_mul_b      = b;
        m_mul_rd     = rd;
        m_mul_tag    = cb_tail;
      end
      if (acc && u == UNIT_LS) begin
        m_ls_load   = ld;
        m_ls_store  = st;
        m_ls_width  = instr[14:12];
        m_ls_base   = a;
        m_ls_offset = b;
        // Store data is the rs2 register named by the encoding
        m_ls_data   = word_t'(instr[24:20]) * REG_SCALE;
        m_ls_rd     = rd;
        m_ls_tag    = cb_tail;
      end
      // Done flags are sticky, busy drops one edge after both are seen
      both_seen = m_si && m_sd;
      if (acc) m_prev = fe;
      m_iflush = start;
      m_dflush = start;
      if (start) begin
        m_busy = 1'b1;
        m_si   = 1'b0;
        m_sd   = 1'b0;
      end else if (m_busy) begin
        if (icache_done) m_si = 1'b1;
        if (dcache_done) m_sd = 1'b1;
        if (both_seen) m_busy = 1'b0;
      end
    end
  end

  always_comb begin : stall_model
    unit_t u;
    alu_op_t op;
    word_t a, b;
    logic ill, mh, ms, ld, st, fe;
    reg_addr_t rd;
    predict(instr, pc, u, op, a, b, ill, mh, ms, ld, st, fe, rd);
    m_stall = instr_valid && (unit_stall_of(u) || m_busy);
  end

  task automatic report(input string name, input logic [63:0] got, input logic [63:0] expv);
    $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, expv, got);
    errors++;
  endtask

  // Outputs change on the rising edge, so compare on the falling edge
  assert property (@(negedge CLK) disable iff (!chk_en) arith_valid == m_arith_valid)
    else report("arith_valid", arith_valid, m_arith_valid);
  assert property (@(negedge CLK) disable iff (!chk_en) mul_valid == m_mul_valid)
    else report("mul_valid", mul_valid, m_mul_valid);
  assert property (@(negedge CLK) disable iff (!chk_en) ls_valid == m_ls_valid)
    else report("ls_valid", ls_valid, m_ls_valid);
  assert property (@(negedge CLK) disable iff (!chk_en) icache_flush == m_iflush)
    else report("icache_flush", icache_flush, m_iflush);
  assert property (@(negedge CLK) disable iff (!chk_en) dcache_flush == m_dflush)
    else report("dcache_flush", dcache_flush, m_dflush);
  assert property (@(negedge CLK) disable iff (!chk_en) fence_busy == m_busy)
    else report("fence_busy", fence_busy, m_busy);
  assert property (@(negedge CLK) disable iff (!chk_en) decode_stall == m_stall)
    else report("decode_stall", decode_stall, m_stall);

  assert property (@(negedge CLK) disable iff (!chk_en)
    m_arith_valid |-> arith_op == m_arith_op && arith_illegal == m_arith_illegal)
    else report("arith_op/illegal", {arith_op, arith_illegal}, {m_arith_op, m_arith_illegal});
  assert property (@(negedge CLK) disable iff (!chk_en)
    m_arith_valid |-> arith_rd == m_arith_rd && arith_tag == m_arith_tag)
    else report("arith_rd/tag", {arith_rd, arith_tag}, {m_arith_rd, m_arith_tag});
  assert property (@(negedge CLK) disable iff (!chk_en)
    m_arith_valid && !m_arith_illegal |-> arith_a == m_arith_a)
    else report("arith_a", arith_a, m_arith_a);
  assert property (@(negedge CLK) disable iff (!chk_en)
    m_arith_valid && !m_arith_illegal |-> arith_b == m_arith_b)
    else report("arith_b", arith_b, m_arith_b);

  assert property (@(negedge CLK) disable iff (!chk_en)
    m_mul_valid |-> {mul_high, mul_signed} == {m_mul_high, m_mul_signed})
    else report("mul_high/signed", {mul_high, mul_signed}, {m_mul_high, m_mul_signed});
  assert property (@(negedge CLK) disable iff (!chk_en) m_mul_valid |-> mul_a == m_mul_a)
    else report("mul_a", mul_a, m_mul_a);
  assert property (@(negedge CLK) disable iff (!chk_en) m_mul_valid |-> mul_b == m_mul_b)
    else report("mul_b", mul_b, m_mul_b);
  assert property (@(negedge CLK) disable iff (!chk_en)
    m_mul_valid |-> mul_rd == m_mul_rd && mul_tag == m_mul_tag)
    else report("mul_rd/tag", {mul_rd, mul_tag}, {m_mul_rd, m_mul_tag});

  assert property (@(negedge CLK) disable iff (!chk_en)
    m_ls_valid |-> {ls_load, ls_store, ls_width} == {m_ls_load, m_ls_store, m_ls_width})
    else report("ls_load/store/width", {ls_load, ls_store, ls_width},
                {m_ls_load, m_ls_store, m_ls_width});
  assert property (@(negedge CLK) disable iff (!chk_en) m_ls_valid |-> ls_base == m_ls_base)
    else report("ls_base", ls_base, m_ls_base);
  assert property (@(negedge CLK) disable iff (!chk_en) m_ls_valid |-> ls_offset == m_ls_offset)
    else report("ls_offset", ls_offset, m_ls_offset);
  assert property (@(negedge CLK) disable iff (!chk_en)
    m_ls_valid |-> ls_store_data == m_ls_data)
    else report("ls_store_data", ls_store_data, m_ls_data);
  assert property (@(negedge CLK) disable iff (!chk_en)
    m_ls_valid |-> ls_rd == m_ls_rd && ls_tag == m_ls_tag)
    else report("ls_rd/tag", {ls_rd, ls_tag}, {m_ls_rd, m_ls_tag});

  function automatic reg_addr_t rreg();
    return reg_addr_t'($urandom % 32);
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input logic [6:0] opc);
    return {f7, rreg(), rreg(), f3, rreg(), opc};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                  input logic [6:0] opc);
    return {imm, rreg(), f3, rreg(), opc};
  endfunction

  task automatic drive(input word_t ins);
    @(posedge CLK);
    instr       <= ins;
    pc          <= {$urandom} & 32'hffff_fffc;
    cb_tail     <= tag_t'($urandom);
    instr_valid <= 1'b1;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge CLK);
      instr_valid <= 1'b0;
    end
  endtask

  task automatic pulse_dones(input int di, input int dd);
    for (int c = 0; c < 8; c++) begin
      @(posedge CLK);
      icache_done <= (c == di);
      dcache_done <= (c == dd);
    end
  endtask

  // Holds the current instruction until decode no longer stalls
  task automatic wait_dispatch();
    int n;
    n = 0;
    @(negedge CLK);
    while (decode_stall && n < 40) begin
      @(negedge CLK);
      n++;
    end
    if (decode_stall) begin
      $display("Timeout: instruction still stalled after 40 cycles");
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  function automatic word_t rand_arith();
    logic [2:0] f3;
    f3 = 3'($urandom);
    case ($urandom % 5)
      0: return enc_r(($urandom % 2 && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00, f3, 7'h33);
      1: begin
        if (f3 == 1) return enc_i({7'h00, 5'($urandom)}, f3, 7'h13);
        if (f3 == 5) return enc_i({($urandom % 2) ? 7'h20 : 7'h00, 5'($urandom)}, f3, 7'h13);
        return enc_i(12'($urandom), f3, 7'h13);
      end
      2: return {20'($urandom), rreg(), 7'h37};
      3: return {20'($urandom), rreg(), 7'h17};
      default: return {25'($urandom), 7'h7f};
    endcase
  endfunction

  function automatic word_t rand_mul_ls();
    logic [11:0] imm;
    imm = 12'($urandom);
    case ($urandom % 3)
      0: return enc_r(7'h01, ($urandom % 3 == 0) ? 3'd3 : 3'($urandom % 2), 7'h33);
      1: return enc_i(imm, ($urandom % 2) ? 3'($urandom % 3) : 3'(4 + $urandom % 2), 7'h03);
      default: return {imm[11:5], rreg(), rreg(), 3'($urandom % 3), imm[4:0], 7'h23};
    endcase
  endfunction

  initial begin
    void'($urandom(60418));
    {nRST, instr_valid, flush, stall_arith, stall_mul, stall_ls} = '0;
    {icache_done, dcache_done} = '0;
    instr = '0;
    pc = '0;
    cb_tail = '0;

    @(posedge CLK);
    chk_en = 1'b1;
    repeat (15) @(posedge CLK);
    nRST <= 1'b1;
    idle(3);
    end_test("reset");

    repeat (40) drive(rand_arith());
    idle(2);
    end_test("arithmetic");

    repeat (40) drive(rand_mul_ls());
    idle(2);
    end_test("multiply and load/store");

    drive(enc_r(7'h01, 3'd0, 7'h33));
    @(posedge CLK);
    stall_mul <= 1'b1;
    repeat (4) drive(enc_r(7'h00, 3'd0, 7'h33));
    drive(enc_r(7'h01, 3'd1, 7'h33));
    repeat (3) @(posedge CLK);
    stall_mul <= 1'b0;
    wait_dispatch();
    idle(2);
    end_test("multiply stall");

    drive(32'h0000_100f);
    drive(enc_r(7'h00, 3'd0, 7'h33));
    pulse_dones(2, 5);
    wait_dispatch();
    idle(2);
    drive(32'h0000_100f);
    drive(32'h0000_100f);
    pulse_dones(4, 1);
    wait_dispatch();
    idle(3);
    end_test("fence");

    drive(enc_r(7'h01, 3'd3, 7'h33));
    drive(enc_r(7'h00, 3'd4, 7'h33));
    stall_mul <= 1'b1;
    @(posedge CLK);
    instr_valid <= 1'b0;
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    stall_mul <= 1'b0;
    idle(2);
    end_test("flush");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hdl/decode_pkg.sv
hdl/decoded_if.sv
hdl/instr_decoder.sv
hdl/operand_select.sv
hdl/dispatch_latches.sv
hdl/fence_tracker.sv
hdl/decode_stage.sv
bench/decode_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module decode_stage_tb -o sim_decode_stage &&
  ./obj_dir/sim_decode_stage | tee /dev/stderr | grep -qx "Done: no errors" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
